//--- alu_cmd_if.sv
`timescale 1ns/100ps

interface alu_cmd_if;

    logic                 start;                     // One cycle, only while busy is low
    saturn_pkg::alu_op_t  op;
    saturn_pkg::reg_sel_t dest;
    saturn_pkg::reg_sel_t src1;
    saturn_pkg::reg_sel_t src2;
    saturn_pkg::nib_ptr_t ptr_begin;
    saturn_pkg::nib_ptr_t ptr_end;

    logic                 busy;                      // Rises the cycle after start
    logic                 carry;

    modport issuer (
        output start, op, dest, src1, src2, ptr_begin, ptr_end,
        input  busy, carry
    );

    modport pipe (
        input  start, op, dest, src1, src2, ptr_begin, ptr_end,
        output busy, carry
    );

endinterface

//--- files.f
saturn_pkg.sv
alu_cmd_if.sv
saturn_apb_regs.sv
saturn_nibble_regs.sv
saturn_alu_pipe.sv
saturn_alu_top.sv
tb_saturn_alu_sva.sv
tb_saturn_alu.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_saturn_alu -f files.f -o tb_saturn_alu

sim_out=$(./obj_dir/tb_saturn_alu)
echo "$sim_out"

if echo "$sim_out" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
exit 1

//--- saturn_alu_pipe.sv
`timescale 1ns/100ps

module saturn_alu_pipe #(
    parameter int REG_NIBBLES = saturn_pkg::REG_NIBBLES_DEF
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    alu_cmd_if.pipe              cmd,
    input  logic                 i_init_busy,
    output saturn_pkg::reg_sel_t o_rd1_reg,
    output saturn_pkg::reg_sel_t o_rd2_reg,
    output saturn_pkg::nib_ptr_t o_rd_idx,
    input  saturn_pkg::nibble_t  i_rd1_val,
    input  saturn_pkg::nibble_t  i_rd2_val,
    output logic                 o_wr1_en,
    output logic                 o_wr2_en,
    output saturn_pkg::reg_sel_t o_wr1_reg,
    output saturn_pkg::reg_sel_t o_wr2_reg,
    output saturn_pkg::nib_ptr_t o_wr_idx,
    output saturn_pkg::nibble_t  o_wr1_val,
    output saturn_pkg::nibble_t  o_wr2_val
);

    saturn_pkg::alu_op_t  op;
    saturn_pkg::reg_sel_t dest;
    saturn_pkg::reg_sel_t src1;
    saturn_pkg::reg_sel_t src2;
    saturn_pkg::nib_ptr_t ptr_begin;
    saturn_pkg::nib_ptr_t ptr_end;

    logic                 accept;
    logic                 prep_run;
    logic                 calc_run;
    logic                 save_run;
    logic                 fin;                           // Trailing cycle after the last save
    saturn_pkg::nib_ptr_t prep_pos;
    saturn_pkg::nib_ptr_t calc_pos;
    saturn_pkg::nib_ptr_t save_pos;
    saturn_pkg::nibble_t  p_src1;
    saturn_pkg::nibble_t  p_src2;
    saturn_pkg::nibble_t  s_res1;
    saturn_pkg::nibble_t  s_res2;
    logic                 chain_c;                       // Carry out of the last calc nibble
    logic                 chain_nz;                      // Any nonzero result so far
    logic                 carry_q;

    logic                 calc_first;
    logic                 cin;
    logic                 nz_cum;
    saturn_pkg::nibble_t  add_a;
    saturn_pkg::nibble_t  add_b;
    logic [4:0]           sum;

    function automatic saturn_pkg::nib_ptr_t next_pos(input saturn_pkg::nib_ptr_t p);
        return (p == saturn_pkg::nib_ptr_t'(REG_NIBBLES - 1)) ? '0 : p + 1'b1;
    endfunction

    assign accept = cmd.start && !i_init_busy;

    // ####################
    // Calculate stage adder

    assign calc_first = (calc_pos == ptr_begin);

    always_comb begin
        cin   = calc_first ? (op == saturn_pkg::OP_2CMPL) : chain_c;
        add_a = p_src1;
        add_b = p_src2;
        if (op == saturn_pkg::OP_2CMPL) begin
            add_a = ~p_src1;                             // Invert and add the chain
            add_b = '0;
        end
        sum    = {1'b0, add_a} + {1'b0, add_b} + {4'b0, cin};
        nz_cum = (calc_first ? 1'b0 : chain_nz) | (|sum[3:0]);
    end

    // ####################
    // Stage control

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            prep_run <= 1'b0;
            calc_run <= 1'b0;
            save_run <= 1'b0;
            fin      <= 1'b0;
            carry_q  <= 1'b0;
        end else begin
            calc_run <= prep_run;
            fin      <= save_run && (save_pos == ptr_end);
            if (prep_run && (prep_pos == ptr_end)) prep_run <= 1'b0;
            if (calc_run) begin
                save_run <= 1'b1;
            end else if (save_run && (save_pos == ptr_end)) begin
                save_run <= 1'b0;
            end
            if (save_run && (save_pos == ptr_end)) begin
                case (op)
                    saturn_pkg::OP_ADD:   carry_q <= chain_c;
                    saturn_pkg::OP_2CMPL: carry_q <= chain_nz;
                    default:              carry_q <= carry_q;
                endcase
            end
            if (accept) begin
                if (cmd.op == saturn_pkg::OP_ZERO) save_run <= 1'b1;   // Straight to save
                else prep_run <= 1'b1;
            end
        end
    end

    // ####################
    // Stage data

    always_ff @(posedge i_clk) begin
        if (accept) begin
            op        <= cmd.op;
            dest      <= cmd.dest;
            src1      <= cmd.src1;
            src2      <= cmd.src2;
            ptr_begin <= cmd.ptr_begin;
            ptr_end   <= cmd.ptr_end;
            prep_pos  <= cmd.ptr_begin;
            calc_pos  <= cmd.ptr_begin;
            save_pos  <= cmd.ptr_begin;
            s_res1    <= '0;                             // What ZERO writes
        end
        if (prep_run) begin
            p_src1   <= i_rd1_val;
            p_src2   <= i_rd2_val;
            prep_pos <= next_pos(prep_pos);
        end
        if (calc_run) begin
            case (op)
                saturn_pkg::OP_EXCH: begin
                    s_res1 <= p_src2;
                    s_res2 <= p_src1;
                end
                saturn_pkg::OP_ADD, saturn_pkg::OP_2CMPL: s_res1 <= sum[3:0];
                default: s_res1 <= p_src1;              // COPY
            endcase
            chain_c  <= sum[4];
            chain_nz <= nz_cum;
            calc_pos <= next_pos(calc_pos);
        end
        if (save_run) save_pos <= next_pos(save_pos);
    end

    assign o_rd1_reg = src1;
    assign o_rd2_reg = src2;
    assign o_rd_idx  = prep_pos;
    assign o_wr1_en  = save_run;
    assign o_wr2_en  = save_run && (op == saturn_pkg::OP_EXCH);
    assign o_wr1_reg = dest;
    assign o_wr2_reg = src2;
    assign o_wr_idx  = save_pos;
    assign o_wr1_val = s_res1;
    assign o_wr2_val = s_res2;

    assign cmd.busy  = !i_init_busy && (prep_run || calc_run || save_run || fin);
    assign cmd.carry = carry_q;

endmodule

//--- saturn_alu_top.sv
`timescale 1ns/100ps

module saturn_alu_top #(
    parameter int REG_NIBBLES = saturn_pkg::REG_NIBBLES_DEF
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [saturn_pkg::APB_AW-1:0] i_paddr,
    input  logic [saturn_pkg::APB_DW-1:0] i_pwdata,
    output logic [saturn_pkg::APB_DW-1:0] o_prdata,
    output logic                          o_pready,
    output logic                          o_pslverr
);

    alu_cmd_if cmd_if ();

    logic                 init_busy;
    logic                 ld_en;
    saturn_pkg::reg_sel_t ld_reg;
    saturn_pkg::nib_ptr_t ld_idx;
    saturn_pkg::nibble_t  ld_val;
    saturn_pkg::reg_sel_t dbg_reg;
    saturn_pkg::nib_ptr_t dbg_idx;
    saturn_pkg::nibble_t  dbg_nibble;

    // Pipe to register file
    saturn_pkg::reg_sel_t rd1_reg;
    saturn_pkg::reg_sel_t rd2_reg;
    saturn_pkg::nib_ptr_t rd_idx;
    saturn_pkg::nibble_t  rd1_val;
    saturn_pkg::nibble_t  rd2_val;
    logic                 wr1_en;
    logic                 wr2_en;
    saturn_pkg::reg_sel_t wr1_reg;
    saturn_pkg::reg_sel_t wr2_reg;
    saturn_pkg::nib_ptr_t wr_idx;
    saturn_pkg::nibble_t  wr1_val;
    saturn_pkg::nibble_t  wr2_val;

    saturn_apb_regs u_apb (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .cmd          (cmd_if.issuer),
        .i_init_busy  (init_busy),
        .o_ld_en      (ld_en),
        .o_ld_reg     (ld_reg),
        .o_ld_idx     (ld_idx),
        .o_ld_val     (ld_val),
        .o_dbg_reg    (dbg_reg),
        .o_dbg_idx    (dbg_idx),
        .i_dbg_nibble (dbg_nibble)
    );

    saturn_nibble_regs #(.REG_NIBBLES(REG_NIBBLES)) u_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .o_init_busy  (init_busy),
        .i_rd1_reg    (rd1_reg),
        .i_rd2_reg    (rd2_reg),
        .i_rd_idx     (rd_idx),
        .o_rd1_val    (rd1_val),
        .o_rd2_val    (rd2_val),
        .i_wr1_en     (wr1_en),
        .i_wr2_en     (wr2_en),
        .i_wr1_reg    (wr1_reg),
        .i_wr2_reg    (wr2_reg),
        .i_wr_idx     (wr_idx),
        .i_wr1_val    (wr1_val),
        .i_wr2_val    (wr2_val),
        .i_ld_en      (ld_en),
        .i_ld_reg     (ld_reg),
        .i_ld_idx     (ld_idx),
        .i_ld_val     (ld_val),
        .i_dbg_reg    (dbg_reg),
        .i_dbg_idx    (dbg_idx),
        .o_dbg_nibble (dbg_nibble)
    );

    saturn_alu_pipe #(.REG_NIBBLES(REG_NIBBLES)) u_pipe (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .cmd          (cmd_if.pipe),
        .i_init_busy  (init_busy),
        .o_rd1_reg    (rd1_reg),
        .o_rd2_reg    (rd2_reg),
        .o_rd_idx     (rd_idx),
        .i_rd1_val    (rd1_val),
        .i_rd2_val    (rd2_val),
        .o_wr1_en     (wr1_en),
        .o_wr2_en     (wr2_en),
        .o_wr1_reg    (wr1_reg),
        .o_wr2_reg    (wr2_reg),
        .o_wr_idx     (wr_idx),
        .o_wr1_val    (wr1_val),
        .o_wr2_val    (wr2_val)
    );

endmodule

//--- saturn_apb_regs.sv
`timescale 1ns/100ps

module saturn_apb_regs (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  logic [saturn_pkg::APB_AW-1:0]     i_paddr,
    input  logic [saturn_pkg::APB_DW-1:0]     i_pwdata,
    output logic [saturn_pkg::APB_DW-1:0]     o_prdata,
    output logic                              o_pready,
    output logic                              o_pslverr,
    alu_cmd_if.issuer                         cmd,
    input  logic                              i_init_busy,
    output logic                              o_ld_en,
    output saturn_pkg::reg_sel_t              o_ld_reg,
    output saturn_pkg::nib_ptr_t              o_ld_idx,
    output saturn_pkg::nibble_t               o_ld_val,
    output saturn_pkg::reg_sel_t              o_dbg_reg,
    output saturn_pkg::nib_ptr_t              o_dbg_idx,
    input  saturn_pkg::nibble_t               i_dbg_nibble
);

    logic access;
    logic is_cmd;
    logic is_status;
    logic is_nib_wr;
    logic is_nib_sel;
    logic cmd_busy;
    logic wr_ok;

    saturn_pkg::reg_sel_t sel_reg;
    saturn_pkg::nib_ptr_t sel_idx;

    // ####################
    // Decode

    assign access     = i_psel && i_penable;
    assign is_cmd     = (i_paddr == saturn_pkg::ADDR_CMD);
    assign is_status  = (i_paddr == saturn_pkg::ADDR_STATUS);
    assign is_nib_wr  = (i_paddr == saturn_pkg::ADDR_NIB_WRITE);
    assign is_nib_sel = (i_paddr == saturn_pkg::ADDR_NIB_SEL);
    assign cmd_busy   = cmd.busy || cmd.start;          // Covers the gap before busy rises

    assign o_pready  = !i_init_busy;                     // Stall only while the regs clear
    assign o_pslverr = access && o_pready &&
                       (!(is_cmd || is_status || is_nib_wr || is_nib_sel) ||
                        (i_pwrite && cmd_busy && (is_cmd || is_nib_wr)));
    assign wr_ok     = access && o_pready && i_pwrite && !o_pslverr;

    // ####################
    // Command issue

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cmd.start <= 1'b0;
            sel_reg   <= saturn_pkg::REG_A;
            sel_idx   <= '0;
        end else begin
            cmd.start <= wr_ok && is_cmd;
            if (wr_ok && is_nib_sel) begin
                sel_reg <= saturn_pkg::reg_sel_t'(i_pwdata[saturn_pkg::NIB_REG_LSB +: 2]);
                sel_idx <= i_pwdata[saturn_pkg::NIB_IDX_LSB +: 4];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_ok && is_cmd) begin
            cmd.op        <= saturn_pkg::alu_op_t'(i_pwdata[saturn_pkg::CMD_OP_LSB +: 3]);
            cmd.dest      <= saturn_pkg::reg_sel_t'(i_pwdata[saturn_pkg::CMD_DEST_LSB +: 2]);
            cmd.src1      <= saturn_pkg::reg_sel_t'(i_pwdata[saturn_pkg::CMD_SRC1_LSB +: 2]);
            cmd.src2      <= saturn_pkg::reg_sel_t'(i_pwdata[saturn_pkg::CMD_SRC2_LSB +: 2]);
            cmd.ptr_begin <= i_pwdata[saturn_pkg::CMD_BEGIN_LSB +: 4];
            cmd.ptr_end   <= i_pwdata[saturn_pkg::CMD_END_LSB +: 4];
        end
    end

    // ####################
    // Nibble load and debug read

    assign o_ld_en   = wr_ok && is_nib_wr;               // Lands on the access edge
    assign o_ld_reg  = saturn_pkg::reg_sel_t'(i_pwdata[saturn_pkg::NIB_REG_LSB +: 2]);
    assign o_ld_idx  = i_pwdata[saturn_pkg::NIB_IDX_LSB +: 4];
    assign o_ld_val  = i_pwdata[saturn_pkg::NIB_VAL_LSB +: 4];
    assign o_dbg_reg = sel_reg;
    assign o_dbg_idx = sel_idx;

    always_comb begin
        o_prdata = '0;
        if (is_status) begin
            o_prdata[saturn_pkg::STAT_BUSY_BIT]  = cmd_busy;
            o_prdata[saturn_pkg::STAT_CARRY_BIT] = cmd.carry;
            o_prdata[saturn_pkg::STAT_INIT_BIT]  = i_init_busy;
        end else if (is_nib_sel) begin
            o_prdata[saturn_pkg::NIB_VAL_LSB +: 4] = i_dbg_nibble;
            o_prdata[saturn_pkg::NIB_IDX_LSB +: 4] = sel_idx;
            o_prdata[saturn_pkg::NIB_REG_LSB +: 2] = sel_reg;
        end
    end

endmodule

//--- saturn_nibble_regs.sv
`timescale 1ns/100ps

module saturn_nibble_regs #(
    parameter int REG_NIBBLES = saturn_pkg::REG_NIBBLES_DEF
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    output logic                 o_init_busy,
    input  saturn_pkg::reg_sel_t i_rd1_reg,
    input  saturn_pkg::reg_sel_t i_rd2_reg,
    input  saturn_pkg::nib_ptr_t i_rd_idx,
    output saturn_pkg::nibble_t  o_rd1_val,
    output saturn_pkg::nibble_t  o_rd2_val,
    input  logic                 i_wr1_en,
    input  logic                 i_wr2_en,
    input  saturn_pkg::reg_sel_t i_wr1_reg,
    input  saturn_pkg::reg_sel_t i_wr2_reg,
    input  saturn_pkg::nib_ptr_t i_wr_idx,
    input  saturn_pkg::nibble_t  i_wr1_val,
    input  saturn_pkg::nibble_t  i_wr2_val,
    input  logic                 i_ld_en,
    input  saturn_pkg::reg_sel_t i_ld_reg,
    input  saturn_pkg::nib_ptr_t i_ld_idx,
    input  saturn_pkg::nibble_t  i_ld_val,
    input  saturn_pkg::reg_sel_t i_dbg_reg,
    input  saturn_pkg::nib_ptr_t i_dbg_idx,
    output saturn_pkg::nibble_t  o_dbg_nibble
);

    saturn_pkg::nibble_t  regs [4][REG_NIBBLES];         // A, B, C, D
    saturn_pkg::nib_ptr_t init_idx;

    // ####################
    // Init sequencer

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            init_idx    <= '0;
            o_init_busy <= 1'b1;
        end else if (o_init_busy) begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == saturn_pkg::nib_ptr_t'(REG_NIBBLES - 1)) begin
                o_init_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_init_busy) begin
            for (int r = 0; r < 4; r++) begin
                regs[r][init_idx] <= '0;                  // One index of every register
            end
        end else begin
            if (i_wr1_en) regs[i_wr1_reg][i_wr_idx] <= i_wr1_val;
            if (i_wr2_en) regs[i_wr2_reg][i_wr_idx] <= i_wr2_val;
            if (i_ld_en) regs[i_ld_reg][i_ld_idx] <= i_ld_val;   // Never overlaps a run
        end
    end

    assign o_rd1_val    = regs[i_rd1_reg][i_rd_idx];
    assign o_rd2_val    = regs[i_rd2_reg][i_rd_idx];
    assign o_dbg_nibble = regs[i_dbg_reg][i_dbg_idx];

endmodule

//--- saturn_pkg.sv
package saturn_pkg;

    // ####################
    // Datapath types

    typedef logic [3:0] nibble_t;
    typedef logic [3:0] nib_ptr_t;                   // Covers the default register length

    typedef enum logic [1:0] {
        REG_A,
        REG_B,
        REG_C,
        REG_D
    } reg_sel_t;

    typedef enum logic [2:0] {
        OP_ZERO,
        OP_COPY,
        OP_EXCH,
        OP_ADD,
        OP_2CMPL
    } alu_op_t;

    localparam int REG_NIBBLES_DEF = 16;

    // ####################
    // APB register map

    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] ADDR_CMD       = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_STATUS    = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_NIB_WRITE = 4'h8;
    localparam logic [APB_AW-1:0] ADDR_NIB_SEL   = 4'hC;

    // Command word fields
    localparam int CMD_OP_LSB    = 0;
    localparam int CMD_DEST_LSB  = 4;
    localparam int CMD_SRC1_LSB  = 6;
    localparam int CMD_SRC2_LSB  = 8;
    localparam int CMD_BEGIN_LSB = 12;
    localparam int CMD_END_LSB   = 16;

    // Nibble load and nibble select words share this layout
    localparam int NIB_VAL_LSB = 0;
    localparam int NIB_IDX_LSB = 4;
    localparam int NIB_REG_LSB = 8;

    // Status word bits
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_CARRY_BIT = 1;
    localparam int STAT_INIT_BIT  = 2;

endpackage

//--- tb_saturn_alu.sv
`timescale 1ns/100ps

module tb_saturn_alu;

    localparam int N          = saturn_pkg::REG_NIBBLES_DEF;
    localparam int WAIT_LIMIT = 200;                     // Cycles or polls per wait

    logic                          i_clk;
    logic                          i_reset;
    logic                          i_psel;
    logic                          i_penable;
    logic                          i_pwrite;
    logic [saturn_pkg::APB_AW-1:0] i_paddr;
    logic [saturn_pkg::APB_DW-1:0] i_pwdata;
    logic [saturn_pkg::APB_DW-1:0] o_prdata;
    logic                          o_pready;
    logic                          o_pslverr;

    saturn_pkg::nibble_t model [4][N];                   // Expected register file
    bit                  model_carry;
    logic [31:0]         lcg_state;
    int                  checks;
    int                  errors;

    saturn_alu_top #(.REG_NIBBLES(N)) dut0 (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    always #10 i_clk = ~i_clk;

    // ####################
    // Random values and checks

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'h0, lcg_state[31:16]};                // Upper bits are the better ones
    endfunction

    function automatic saturn_pkg::reg_sel_t rand_reg();
        logic [31:0] v;
        v = lcg_next();
        return saturn_pkg::reg_sel_t'(v[1:0]);
    endfunction

    function automatic saturn_pkg::nibble_t rand_nibble();
        logic [31:0] v;
        v = lcg_next();
        return v[3:0];
    endfunction

    task automatic compare_nibble(input string name, input saturn_pkg::nibble_t got,
                                  input saturn_pkg::nibble_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_carry(input bit got, input bit exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch carry: got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic compare_err(input string name, input bit got, input bit exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    // ####################
    // APB access

    task automatic apb_access(input logic [3:0] addr, input bit write, input logic [31:0] wdata,
                              output logic [31:0] rdata, output bit err, output int waits);
        int n;
        n = 0;
        @(posedge i_clk);
        #1;
        i_psel    = 1'b1;                                // Setup phase
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(posedge i_clk);
        #1;
        i_penable = 1'b1;
        @(negedge i_clk);                                // Outputs are settled mid-cycle
        while (!o_pready && n < WAIT_LIMIT) begin
            n++;
            @(negedge i_clk);
        end
        if (!o_pready) report_failure("APB transfer timed out waiting for PREADY");
        rdata = o_prdata;
        err   = o_pslverr;
        waits = n;
        @(posedge i_clk);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output bit err);
        logic [31:0] unused_rd;
        int          waits;
        apb_access(addr, 1'b1, data, unused_rd, err, waits);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output int waits);
        bit err;
        apb_access(addr, 1'b0, '0, data, err, waits);
        compare_err("pslverr on read", err, 1'b0);
    endtask

    function automatic logic [31:0] cmd_word(
        input saturn_pkg::alu_op_t op, input saturn_pkg::reg_sel_t dest,
        input saturn_pkg::reg_sel_t src1, input saturn_pkg::reg_sel_t src2,
        input saturn_pkg::nib_ptr_t b, input saturn_pkg::nib_ptr_t e);
        logic [31:0] w;
        w = '0;
        w[saturn_pkg::CMD_OP_LSB +: 3]    = op;
        w[saturn_pkg::CMD_DEST_LSB +: 2]  = dest;
        w[saturn_pkg::CMD_SRC1_LSB +: 2]  = src1;
        w[saturn_pkg::CMD_SRC2_LSB +: 2]  = src2;
        w[saturn_pkg::CMD_BEGIN_LSB +: 4] = b;
        w[saturn_pkg::CMD_END_LSB +: 4]   = e;
        return w;
    endfunction

    function automatic logic [31:0] nib_word(input saturn_pkg::reg_sel_t r,
                                             input saturn_pkg::nib_ptr_t idx,
                                             input saturn_pkg::nibble_t val);
        logic [31:0] w;
        w = '0;
        w[saturn_pkg::NIB_VAL_LSB +: 4] = val;
        w[saturn_pkg::NIB_IDX_LSB +: 4] = idx;
        w[saturn_pkg::NIB_REG_LSB +: 2] = r;
        return w;
    endfunction

    // ####################
    // Register and status readback

    task automatic read_nibble(input saturn_pkg::reg_sel_t r, input saturn_pkg::nib_ptr_t idx,
                               output saturn_pkg::nibble_t val);
        logic [31:0] d;
        bit          err;
        int          waits;
        apb_write(saturn_pkg::ADDR_NIB_SEL, nib_word(r, idx, 4'h0), err);
        compare_err("pslverr on nibble select", err, 1'b0);
        apb_read(saturn_pkg::ADDR_NIB_SEL, d, waits);
        val = d[saturn_pkg::NIB_VAL_LSB +: 4];
    endtask

    task automatic check_regs();
        saturn_pkg::reg_sel_t sel;
        saturn_pkg::nibble_t  got;
        for (int r = 0; r < 4; r++) begin
            sel = saturn_pkg::reg_sel_t'(r);
            for (int i = 0; i < N; i++) begin
                read_nibble(sel, saturn_pkg::nib_ptr_t'(i), got);
                compare_nibble($sformatf("%s[%0d]", sel.name(), i), got, model[r][i]);
            end
        end
    endtask

    task automatic check_carry();
        logic [31:0] d;
        int          waits;
        apb_read(saturn_pkg::ADDR_STATUS, d, waits);
        compare_carry(d[saturn_pkg::STAT_CARRY_BIT], model_carry);
    endtask

    task automatic wait_idle();
        logic [31:0] d;
        int          n;
        int          waits;
        n = 0;
        apb_read(saturn_pkg::ADDR_STATUS, d, waits);
        while (d[saturn_pkg::STAT_BUSY_BIT] && n < WAIT_LIMIT) begin
            n++;
            apb_read(saturn_pkg::ADDR_STATUS, d, waits);
        end
        if (d[saturn_pkg::STAT_BUSY_BIT]) report_failure("ALU stayed busy past the timeout");
    endtask

    // ####################
    // Reference model

    function automatic saturn_pkg::nib_ptr_t next_index(input saturn_pkg::nib_ptr_t p);
        return (p == saturn_pkg::nib_ptr_t'(N - 1)) ? '0 : p + 4'd1;   // Field wraps around
    endfunction

    task automatic model_run(input saturn_pkg::alu_op_t op, input saturn_pkg::reg_sel_t dest,
                             input saturn_pkg::reg_sel_t src1, input saturn_pkg::reg_sel_t src2,
                             input saturn_pkg::nib_ptr_t b, input saturn_pkg::nib_ptr_t e);
        saturn_pkg::nib_ptr_t p;
        saturn_pkg::nibble_t  x;
        saturn_pkg::nibble_t  y;
        logic [4:0]           s;
        logic                 c;
        logic                 nz;
        p  = b;
        c  = (op == saturn_pkg::OP_2CMPL);              // Two's complement adds one at the start
        nz = 1'b0;
        for (int k = 0; k < N; k++) begin
            x = model[src1][p];
            y = model[src2][p];
            case (op)
                saturn_pkg::OP_ZERO: model[dest][p] = 4'h0;
                saturn_pkg::OP_COPY: model[dest][p] = x;
                saturn_pkg::OP_EXCH: begin
                    model[dest][p] = y;
                    model[src2][p] = x;                  // Second write lands last
                end
                saturn_pkg::OP_ADD: begin
                    s = {1'b0, x} + {1'b0, y} + {4'b0, c};
                    model[dest][p] = s[3:0];
                    c = s[4];
                end
                default: begin
                    s = {1'b0, ~x} + {4'b0, c};
                    model[dest][p] = s[3:0];
                    c  = s[4];
                    nz = nz | (s[3:0] != 4'h0);
                end
            endcase
            if (p == e) break;
            p = next_index(p);
        end
        if (op == saturn_pkg::OP_ADD) model_carry = c;
        else if (op == saturn_pkg::OP_2CMPL) model_carry = nz;
    endtask

    task automatic run_cmd(input saturn_pkg::alu_op_t op, input saturn_pkg::reg_sel_t dest,
                           input saturn_pkg::reg_sel_t src1, input saturn_pkg::reg_sel_t src2,
                           input saturn_pkg::nib_ptr_t b, input saturn_pkg::nib_ptr_t e);
        bit err;
        apb_write(saturn_pkg::ADDR_CMD, cmd_word(op, dest, src1, src2, b, e), err);
        compare_err("pslverr on command", err, 1'b0);
        wait_idle();
        model_run(op, dest, src1, src2, b, e);
        check_regs();
        check_carry();
    endtask

    task automatic reset_dut();
        i_reset = 1'b1;
        repeat (8) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        model_carry = 1'b0;                              // Reset clears carry and init the regs
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < N; i++) model[r][i] = 4'h0;
        end
    endtask

    // ####################
    // Tests

    task automatic test_reset_init(input string name);
        logic [31:0] d;
        int          waits;
        int          e0;
        e0 = errors;
        apb_read(saturn_pkg::ADDR_STATUS, d, waits);
        if (waits == 0) report_failure("status read did not stall during init");
        if (d[saturn_pkg::STAT_INIT_BIT]) report_failure("init bit still set after the stall");
        compare_carry(d[saturn_pkg::STAT_CARRY_BIT], 1'b0);
        check_regs();
        report_test(name, e0);
    endtask

    task automatic test_load_read();
        saturn_pkg::nibble_t v;
        bit                  err;
        int                  e0;
        e0 = errors;
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < N; i++) begin
                v = rand_nibble();
                apb_write(saturn_pkg::ADDR_NIB_WRITE,
                          nib_word(saturn_pkg::reg_sel_t'(r), saturn_pkg::nib_ptr_t'(i), v), err);
                compare_err("pslverr on nibble load", err, 1'b0);
                model[r][i] = v;
            end
        end
        check_regs();
        report_test("load_read", e0);
    endtask

    task automatic test_move_ops();
        saturn_pkg::alu_op_t op;
        logic [31:0]         v;
        int                  e0;
        e0 = errors;
        repeat (6) begin
            v  = lcg_next();
            op = (v % 3 == 0) ? saturn_pkg::OP_ZERO :
                 (v % 3 == 1) ? saturn_pkg::OP_COPY : saturn_pkg::OP_EXCH;
            run_cmd(op, rand_reg(), rand_reg(), rand_reg(), rand_nibble(), rand_nibble());
        end
        report_test("copy_zero_exch", e0);
    endtask

    task automatic test_arith();
        saturn_pkg::alu_op_t op;
        int                  e0;
        e0 = errors;
        for (int t = 0; t < 8; t++) begin
            op = (t % 2 == 0) ? saturn_pkg::OP_ADD : saturn_pkg::OP_2CMPL;
            run_cmd(op, rand_reg(), rand_reg(), rand_reg(), rand_nibble(), rand_nibble());
        end
        report_test("add_2cmpl", e0);
    endtask

    task automatic test_busy_reject();
        bit err;
        int e0;
        e0 = errors;
        apb_write(saturn_pkg::ADDR_CMD, cmd_word(saturn_pkg::OP_ADD, saturn_pkg::REG_C,
                  saturn_pkg::REG_A, saturn_pkg::REG_B, 4'h0, 4'hF), err);
        compare_err("pslverr on first command", err, 1'b0);
        apb_write(saturn_pkg::ADDR_CMD, cmd_word(saturn_pkg::OP_ZERO, saturn_pkg::REG_C,
                  saturn_pkg::REG_A, saturn_pkg::REG_A, 4'h0, 4'hF), err);
        compare_err("pslverr on command while busy", err, 1'b1);
        wait_idle();
        model_run(saturn_pkg::OP_ADD, saturn_pkg::REG_C, saturn_pkg::REG_A,
                  saturn_pkg::REG_B, 4'h0, 4'hF);
        check_regs();
        check_carry();
        report_test("busy_reject", e0);
    endtask

    task automatic test_carry_set();
        bit err;
        int e0;
        e0 = errors;
        apb_write(saturn_pkg::ADDR_NIB_WRITE, nib_word(saturn_pkg::REG_A, 4'h0, 4'h1), err);
        compare_err("pslverr on nibble load", err, 1'b0);
        model[saturn_pkg::REG_A][0] = 4'h1;
        run_cmd(saturn_pkg::OP_2CMPL, saturn_pkg::REG_D, saturn_pkg::REG_A,
                saturn_pkg::REG_A, 4'h0, 4'h0);          // Nonzero result leaves carry set
        report_test("carry_set", e0);
    endtask

    initial begin
        i_clk     = 1'b0;
        i_reset   = 1'b1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        lcg_state = 32'd20;
        checks    = 0;
        errors    = 0;
        reset_dut();
        test_reset_init("reset_init");
        test_load_read();
        test_move_ops();
        test_arith();
        test_busy_reject();
        test_carry_set();
        reset_dut();
        test_reset_init("reset_after_use");
        $display("done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb_saturn_alu_sva.sv
`timescale 1ns/100ps

module tb_saturn_alu_sva (
    input logic i_clk,
    input logic i_reset,
    input logic i_psel,
    input logic i_penable,
    input logic i_pslverr,
    input logic i_start,
    input logic i_busy
);

    // ####################
    // APB protocol

    a_err_in_access: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_pslverr |-> (i_psel && i_penable)
    ) else $error("PSLVERR high outside the access phase");

    // ####################
    // Command handshake

    a_start_when_idle: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_start |-> !i_busy
    ) else $error("start pulsed while the pipe was busy");

    a_busy_after_start: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_start |=> i_busy
    ) else $error("busy did not rise the cycle after start");

endmodule

bind saturn_apb_regs tb_saturn_alu_sva sva0 (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pslverr (o_pslverr),
    .i_start   (cmd.start),
    .i_busy    (cmd.busy)
);
